/* rom_loader_top.f */
verilog/loader_types_pkg.sv
verilog/rom_header_pkg.sv
verilog/loader_if.sv
verilog/dl_byte_rx.sv
verilog/rom_region_map.sv
verilog/cfg_reg_bank.sv
verilog/sdram_prog_port.sv
verilog/rom_loader_top.sv
tb/rom_loader_chk.sv
tb/rom_loader_tb.sv

/* Bender.yml */
package:
  name: rom_loader

sources:
  - files:
      - verilog/loader_types_pkg.sv
      - verilog/rom_header_pkg.sv
      - verilog/loader_if.sv
      - verilog/dl_byte_rx.sv
      - verilog/rom_region_map.sv
      - verilog/cfg_reg_bank.sv
      - verilog/sdram_prog_port.sv
      - verilog/rom_loader_top.sv
  - target: test
    files:
      - tb/rom_loader_chk.sv
      - tb/rom_loader_tb.sv

/* tb/rom_loader_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for rom_loader_top
// host and SDRAM are behavioral models
// starts fixed at 1024/1280/1536 KB
// header bytes 6, 7 and 40..63 never sent
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rom_loader_tb;
    import loader_types_pkg::*;

    localparam int REGSIZE = 24;
    localparam int CLK_PERIOD = 20;
    localparam sdram_addr_t CPU_OFF = 22'h010000;
    localparam sdram_addr_t SND_OFF = 22'h100000;
    localparam sdram_addr_t SMP_OFF = 22'h200000;
    localparam sdram_addr_t GFX_OFF = 22'h300000;
    localparam int SND_KB = 1024, SMP_KB = 1280, GFX_KB = 1536;
    localparam int BODY = 64;                        // body offset in the image
    localparam int HDR_BYTES = 6 + REGSIZE + 8;      // starts plus config 8..39
    localparam int N_RANDOM = 40;
    localparam int TOTAL_BYTES = 2 * HDR_BYTES + 6 + 6 + 7 + 3 * 5 + N_RANDOM;
    localparam byte_t XOR_KEY [8] = '{8'h04, 8'h21, 8'h01, 8'h50,
                                      8'h40, 8'h06, 8'h08, 8'h88};
    localparam dl_addr_t CPU_BULK [6] = '{0, 1, 2, 3, 25'h1234, 25'h1235};
    localparam dl_addr_t BND_BULK [7] = '{SND_KB * 1024 - 1, SND_KB * 1024,
        SMP_KB * 1024 - 1, SMP_KB * 1024, GFX_KB * 1024 - 1, GFX_KB * 1024,
        GFX_KB * 1024 + 1};
    localparam dl_addr_t DEC_BULK [5] = '{25'h80000, 25'h80001, 25'h80002,
        25'h00100, 25'h180000};                     // last one gfx, bit 19 set
    localparam byte_t DEC_DATA [5] = '{8'hA5, 8'h3C, 8'h00, 8'hFF, 8'h5A};

    logic clk = 1'b0;
    logic reset, downloading, dl_req, dl_ack, prog_we, sdram_ack;
    dl_addr_t dl_addr;
    byte_t dl_data, prog_data;
    sdram_addr_t prog_addr;
    lane_mask_t prog_mask;
    bank_t prog_bank;
    logic [8*REGSIZE-1:0] cfg_data;

    logic [33:0] expected [$];   // {addr, data, mask, bank}
    logic decrypt_on = 1'b0;     // flag as the loader should hold it
    int seed = 89;
    int errors = 0, tests_run = 0, tests_failed = 0;
    int mark, delay;

    rom_loader_top #(
        .REGSIZE(REGSIZE), .CPU_OFFSET(CPU_OFF), .SND_OFFSET(SND_OFF),
        .SMP_OFFSET(SMP_OFF), .GFX_OFFSET(GFX_OFF), .CFG_BYTE(6'd39)
    ) dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int total_errors();
        return errors + dut_i.chk_i.fail_count;
    endfunction

    function automatic byte_t cfg_val(input int a);
        return byte_t'(a * 29 + 7);
    endfunction

    // bits 3 and 7 count when low
    function automatic byte_t descramble(input byte_t d);
        byte_t r;
        logic hit;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            hit = (i == 3 || i == 7) ? !d[i] : d[i];
            if (hit)
                r = r ^ XOR_KEY[i];
        end
        return r;
    endfunction

    function automatic logic [33:0] expect_write(input dl_addr_t bulk, input byte_t d);
        sdram_addr_t w;
        bank_t b;
        byte_t q;
        int kb;
        kb = int'(bulk) / 1024;
        q = d;
        if (kb < SND_KB) begin
            w = sdram_addr_t'(int'(bulk) / 2) + CPU_OFF;   // cpu, no start subtracted
            b = 2'b01;
            if (decrypt_on && bulk[19] && !bulk[0])
                q = descramble(d);
        end else if (kb < SMP_KB) begin
            w = sdram_addr_t'((int'(bulk) - SND_KB * 1024) / 2) + SND_OFF;
            b = 2'b00;
        end else if (kb < GFX_KB) begin
            w = sdram_addr_t'((int'(bulk) - SMP_KB * 1024) / 2) + SMP_OFF;
            b = 2'b00;
        end else begin
            w = sdram_addr_t'((int'(bulk) - GFX_KB * 1024) / 2) + GFX_OFF;
            b = 2'b10;
        end
        return {w, q, (bulk[0] ? 2'b01 : 2'b10), b};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // one four-phase transfer
    task automatic send_byte(input dl_addr_t a, input byte_t d);
        @(negedge clk);
        dl_addr = a;
        dl_data = d;
        dl_req = 1'b1;
        while (!dl_ack) @(negedge clk);
        dl_req = 1'b0;
        while (dl_ack) @(negedge clk);
    endtask

    task automatic send_body(input dl_addr_t bulk, input byte_t d);
        expected.push_back(expect_write(bulk, d));
        send_byte(dl_addr_t'(bulk + BODY), d);
    endtask

    task automatic send_starts();
        int starts [3];
        starts = '{SND_KB, SMP_KB, GFX_KB};
        for (int i = 0; i < 6; i++)                  // little endian pairs
            send_byte(dl_addr_t'(i), byte_t'(starts[i / 2] >> (8 * (i % 2))));
    endtask

    task automatic send_cfg(input logic flag);
        byte_t v;
        for (int a = 8; a < REGSIZE + 16; a++) begin
            v = cfg_val(a);
            if (a == 39)
                v[7] = flag;                 // decrypt enable bit
            send_byte(dl_addr_t'(a), v);
        end
        decrypt_on = flag;
    endtask

    task automatic check_cfg(input logic cleared);
        for (int i = 0; i < REGSIZE; i++)
            compare($sformatf("cfg_data[%0d]", i), cfg_data[8*i +: 8],
                    cleared ? 8'h00 : cfg_val(8 + i));
    endtask

    task automatic wait_idle();
        while (expected.size() != 0 || prog_we || sdram_ack) @(negedge clk);
    endtask

    task automatic restart();
        wait_idle();
        downloading = 1'b0;
        decrypt_on = 1'b0;                   // loader clears it too
        repeat (3) @(negedge clk);
        downloading = 1'b1;
    endtask

    task automatic finish_test(input string name, input int start_errs);
        int n;
        wait_idle();
        repeat (3) @(negedge clk);           // late assertion hits land here
        n = total_errors() - start_errs;
        tests_run++;
        if (n == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, n);
        end
    endtask

    // SDRAM model, checks each write then acks after 0..5 cycles
    always begin
        @(negedge clk);
        if (prog_we) begin
            if (expected.size() == 0) begin
                $display("ERROR at %0t: SDRAM write at %h with none expected", $time, prog_addr);
                errors++;
            end else begin
                logic [33:0] e;
                e = expected.pop_front();
                compare("prog_addr", prog_addr, e[33:12]);
                compare("prog_data", prog_data, e[11:4]);
                compare("prog_mask", prog_mask, e[3:2]);
                compare("prog_bank", prog_bank, e[1:0]);
            end
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) @(negedge clk);
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
        end
    end

    // watchdog, 200 cycles per host byte
    initial begin
        #(CLK_PERIOD * (200 * TOTAL_BYTES + 20));
        $display("timeout: run did not finish after %0d host bytes' worth", TOTAL_BYTES);
        $display("tests failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        downloading = 1'b0;
        dl_req = 1'b0;
        dl_addr = '0;
        dl_data = '0;
        sdram_ack = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        downloading = 1'b1;

        mark = total_errors();               // header gives no SDRAM writes
        send_starts();
        send_cfg(1'b0);
        wait_idle();
        check_cfg(1'b0);
        finish_test("header and config", mark);

        mark = total_errors();
        foreach (CPU_BULK[i]) send_body(CPU_BULK[i], byte_t'(8'h10 + i));
        finish_test("cpu region", mark);

        mark = total_errors();
        foreach (BND_BULK[i]) send_body(BND_BULK[i], byte_t'(8'hC0 + i));
        finish_test("region boundaries", mark);

        mark = total_errors();
        foreach (DEC_BULK[i]) send_body(DEC_BULK[i], DEC_DATA[i]);   // flag clear
        restart();
        send_starts();
        send_cfg(1'b1);
        foreach (DEC_BULK[i]) send_body(DEC_BULK[i], DEC_DATA[i]);
        finish_test("cpu decryption", mark);

        mark = total_errors();
        for (int i = 0; i < N_RANDOM; i++)
            send_body(dl_addr_t'($unsigned($random(seed)) % (2 * 1024 * 1024)),
                      byte_t'($random(seed)));
        finish_test("random sdram delay", mark);

        mark = total_errors();
        restart();                           // no config bytes this time
        send_starts();
        check_cfg(1'b1);
        foreach (DEC_BULK[i]) send_body(DEC_BULK[i], DEC_DATA[i]);
        finish_test("flag cleared on restart", mark);

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/rom_loader_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol assertions for rom_loader_top
// bound into every instance of the top
// fail_count is read by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rom_loader_chk (
    input wire                           clk,
    input wire                           reset,
    input wire                           downloading,
    input wire                           dl_req,
    input wire                           dl_ack,
    input loader_types_pkg::sdram_addr_t prog_addr,
    input loader_types_pkg::byte_t       prog_data,
    input loader_types_pkg::lane_mask_t  prog_mask,
    input loader_types_pkg::bank_t       prog_bank,
    input wire                           prog_we,
    input wire                           sdram_ack
);
    int   fail_count = 0;
    logic ack_q;                 // dl_ack, last cycle
    logic ack_rise;              // same cycle as dl.wr

    always_ff @(posedge clk) begin
        if (reset)
            ack_q <= 1'b0;
        else
            ack_q <= dl_ack;
    end

    assign ack_rise = dl_ack && !ack_q;

    // pending write keeps its fields
    fields_stable: assert property (@(posedge clk) disable iff (reset)
        prog_we && !sdram_ack && downloading |=>
            prog_we && $stable({prog_addr, prog_data, prog_mask, prog_bank}))
        else begin $error("prog fields changed before sdram_ack"); fail_count++; end

    // back-pressure while SDRAM write open
    no_ack_while_busy: assert property (@(posedge clk) disable iff (reset)
        prog_we && !sdram_ack |=> !$rose(dl_ack))
        else begin $error("dl_ack rose with a write pending"); fail_count++; end

    ack_falls_after_req: assert property (@(posedge clk) disable iff (reset)
        $fell(dl_ack) |-> $past(!dl_req))
        else begin $error("dl_ack fell while dl_req high"); fail_count++; end

    // accept edge to prog_we, 2 cycles
    we_latency: assert property (@(posedge clk) disable iff (reset)
        $rose(prog_we) |-> $past(ack_rise, 2))
        else begin $error("prog_we latency not 2 cycles"); fail_count++; end

endmodule

bind rom_loader_top rom_loader_chk chk_i (.*);

`default_nettype wire

/* verilog/rom_loader_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM download loader, host to SDRAM
// host side four-phase req/ack, one byte
// dl_req assumed synchronous to clk
// wr to prog_we latency is 2 cycles
// cfg_data slot 0 is header byte 8
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rom_loader_top #(
    parameter int                            REGSIZE    = 24,
    parameter loader_types_pkg::sdram_addr_t CPU_OFFSET = '0,
    parameter loader_types_pkg::sdram_addr_t SND_OFFSET = '0,
    parameter loader_types_pkg::sdram_addr_t SMP_OFFSET = '0,
    parameter loader_types_pkg::sdram_addr_t GFX_OFFSET = '0,
    parameter logic [5:0]                    CFG_BYTE   = 6'd39
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           downloading,
    input  wire                           dl_req,
    output logic                          dl_ack,
    input  loader_types_pkg::dl_addr_t    dl_addr,
    input  loader_types_pkg::byte_t       dl_data,
    output loader_types_pkg::sdram_addr_t prog_addr,
    output loader_types_pkg::byte_t       prog_data,
    output loader_types_pkg::lane_mask_t  prog_mask,
    output loader_types_pkg::bank_t       prog_bank,
    output logic                          prog_we,
    input  wire                           sdram_ack,
    output logic [8*REGSIZE-1:0]          cfg_data
);

    dl_if   dl_bus ();
    prog_if prog_bus ();

    logic                       cfg_we;
    logic [$clog2(REGSIZE)-1:0] cfg_addr;

    dl_byte_rx rx_i (
        .clk, .reset, .dl_req, .dl_addr, .dl_data, .downloading, .dl_ack,
        .dl(dl_bus.source), .prog(prog_bus.monitor)
    );

    rom_region_map #(
        .REGSIZE(REGSIZE), .CPU_OFFSET(CPU_OFFSET), .SND_OFFSET(SND_OFFSET),
        .SMP_OFFSET(SMP_OFFSET), .GFX_OFFSET(GFX_OFFSET), .CFG_BYTE(CFG_BYTE)
    ) map_i (
        .clk, .reset, .dl(dl_bus.sink), .prog(prog_bus.map), .cfg_we, .cfg_addr
    );

    cfg_reg_bank #(.REGSIZE(REGSIZE)) cfg_i (
        .clk, .reset, .cfg_we, .cfg_addr, .dl(dl_bus.sink), .cfg_data
    );

    sdram_prog_port port_i (
        .clk, .reset, .downloading, .sdram_ack, .prog(prog_bus.port),
        .prog_addr, .prog_data, .prog_mask, .prog_bank, .prog_we
    );

endmodule

`default_nettype wire

/* verilog/sdram_prog_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM programming port
// one write outstanding at a time
// fields stable while prog_we is high
// prog_we drops on sdram_ack or end of load
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sdram_prog_port (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           downloading,
    input  wire                           sdram_ack,
    prog_if.port                          prog,
    output loader_types_pkg::sdram_addr_t prog_addr,
    output loader_types_pkg::byte_t       prog_data,
    output loader_types_pkg::lane_mask_t  prog_mask,
    output loader_types_pkg::bank_t       prog_bank,
    output logic                          prog_we
);

    // busy from map strobe until the write is acked
    assign prog.busy = prog.we || prog_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else if (prog.we) begin
            prog_we <= 1'b1;                 // 2 cycles after dl.wr
        end else if (sdram_ack || !downloading) begin
            prog_we <= 1'b0;
        end
    end

    // payload, latched only on a new write
    always_ff @(posedge clk) begin
        if (prog.we) begin
            prog_addr <= prog.addr;
            prog_data <= prog.data;
            prog_mask <= prog.mask;
            prog_bank <= prog.bank;
        end
    end

endmodule

`default_nettype wire

/* verilog/cfg_reg_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// board configuration byte store
// slot 0 holds header byte 8
// cleared on reset and on download start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cfg_reg_bank #(
    parameter int REGSIZE = 24
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         cfg_we,
    input  wire [$clog2(REGSIZE)-1:0]   cfg_addr,
    dl_if.sink                          dl,
    output logic [8*REGSIZE-1:0]        cfg_data
);
    import loader_types_pkg::*;

    byte_t regs [REGSIZE];
    logic  dl_q;             // downloading, last cycle
    logic  dl_start;

    assign dl_start = dl.downloading && !dl_q;

    always_ff @(posedge clk) begin
        if (reset)
            dl_q <= 1'b0;
        else
            dl_q <= dl.downloading;
    end

    always_ff @(posedge clk) begin
        if (reset || dl_start) begin
            for (int i = 0; i < REGSIZE; i++)
                regs[i] <= '0;
        end else if (cfg_we && cfg_addr < REGSIZE) begin
            regs[cfg_addr] <= dl.data;   // rx holds data until next byte
        end
    end

    // flat view, slot 0 in the low byte
    always_comb begin
        for (int i = 0; i < REGSIZE; i++)
            cfg_data[8*i +: 8] = regs[i];
    end

endmodule

`default_nettype wire

/* verilog/rom_region_map.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// header decode and body byte placement
// region starts taken from bytes 0..5
// config bytes 8..REGSIZE+15 go to cfg bank
// outputs registered, 1 cycle after dl.wr
// decrypt flag clears while not downloading
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rom_region_map #(
    parameter int                            REGSIZE    = 24,
    parameter loader_types_pkg::sdram_addr_t CPU_OFFSET = '0,
    parameter loader_types_pkg::sdram_addr_t SND_OFFSET = '0,
    parameter loader_types_pkg::sdram_addr_t SMP_OFFSET = '0,
    parameter loader_types_pkg::sdram_addr_t GFX_OFFSET = '0,
    parameter logic [5:0]                    CFG_BYTE   = 6'd39
) (
    input  wire                         clk,
    input  wire                         reset,
    dl_if.sink                          dl,
    prog_if.map                         prog,
    output logic                        cfg_we,
    output logic [$clog2(REGSIZE)-1:0]  cfg_addr
);
    import loader_types_pkg::*;
    import rom_header_pkg::*;

    localparam int STARTW = 8 * START_BYTES;
    localparam int CFG_AW = $clog2(REGSIZE);

    logic [STARTW-1:0] starts;              // shifted in, byte 0 ends lowest
    region_start_t     snd_start, smp_start, gfx_start;
    dl_addr_t          bulk;                // body-relative byte address
    dl_addr_t          snd_rel, smp_rel, gfx_rel;
    dl_addr_t          cfg_off;
    region_start_t     bulk_kb;
    logic              is_start, is_cfg;
    logic              is_cpu, is_snd, is_smp, is_gfx;
    logic              decrypt;             // header flag
    logic              do_decrypt;
    byte_t             dec_data;
    sdram_addr_t       word_addr;
    bank_t             bank;

    assign snd_start = starts[15:0];
    assign smp_start = starts[31:16];
    assign gfx_start = starts[47:32];

    assign bulk    = dl.addr - dl_addr_t'(FULL_HEADER);
    assign bulk_kb = {1'b0, bulk[24:10]};
    assign snd_rel = bulk - {snd_start[14:0], 10'd0};
    assign smp_rel = bulk - {smp_start[14:0], 10'd0};
    assign gfx_rel = bulk - {gfx_start[14:0], 10'd0};
    assign cfg_off = dl.addr - dl_addr_t'(8);

    assign is_start = dl.addr < START_BYTES;
    assign is_cfg   = dl.addr > 7 && dl.addr < REGSIZE + START_HEADER;

    // starts assumed ascending: snd <= smp <= gfx
    assign is_cpu = bulk_kb < snd_start;
    assign is_snd = !is_cpu && bulk_kb < smp_start;
    assign is_smp = !is_cpu && !is_snd && bulk_kb < gfx_start;
    assign is_gfx = bulk_kb >= gfx_start;

    // only even cpu bytes in the upper half are scrambled
    assign do_decrypt = decrypt && is_cpu && bulk[19] && !bulk[0];

    always_comb begin
        dec_data = '0;
        for (int i = 0; i < 8; i++) begin
            if (dl.data[i] ^ DECRYPT_INVERT[i])
                dec_data = dec_data ^ DECRYPT_MASKS[i];
        end
    end

    always_comb begin
        if (is_cpu)
            word_addr = bulk[22:1] + CPU_OFFSET;      // cpu uses bulk directly
        else if (is_snd)
            word_addr = snd_rel[22:1] + SND_OFFSET;
        else if (is_smp)
            word_addr = smp_rel[22:1] + SMP_OFFSET;
        else
            word_addr = gfx_rel[22:1] + GFX_OFFSET;
    end

    assign bank = is_cpu ? 2'b01 : (is_gfx ? 2'b10 : 2'b00);

    // strobes and decrypt flag
    always_ff @(posedge clk) begin
        if (reset) begin
            prog.we <= 1'b0;
            cfg_we  <= 1'b0;
            decrypt <= 1'b0;
        end else begin
            prog.we <= 1'b0;
            cfg_we  <= 1'b0;
            if (!dl.downloading) begin
                decrypt <= 1'b0;                      // new image, new flag
            end else if (dl.wr && !is_start) begin
                if (is_cfg) begin
                    cfg_we <= 1'b1;
                    if (dl.addr[5:0] == CFG_BYTE)
                        decrypt <= dl.data[7];
                end else begin
                    prog.we <= 1'b1;                  // bytes 6, 7 land here too
                end
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (dl.wr && dl.downloading) begin
            if (is_start)
                starts <= {dl.data, starts[STARTW-1:8]};
            prog.addr <= word_addr;
            prog.data <= do_decrypt ? dec_data : dl.data;
            prog.mask <= bulk[0] ? 2'b01 : 2'b10;     // active low lane
            prog.bank <= bank;
            cfg_addr  <= cfg_off[CFG_AW-1:0];
        end
    end

endmodule

`default_nettype wire

/* verilog/dl_byte_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-phase req/ack byte receiver
// dl_req must already be in the clk domain
// addr/data stable while dl_req is high
// no byte taken while an SDRAM write pends
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dl_byte_rx (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       dl_req,
    input  loader_types_pkg::dl_addr_t dl_addr,
    input  loader_types_pkg::byte_t   dl_data,
    input  wire                       downloading,
    output logic                      dl_ack,
    dl_if.source                      dl,
    prog_if.monitor                   prog
);
    import loader_types_pkg::*;

    logic     accept;      // byte taken this cycle
    dl_addr_t addr_q;
    byte_t    data_q;
    logic     wr_q;

    // new req, previous handshake closed, output side free
    assign accept = dl_req && !dl_ack && !prog.busy && downloading;

    // control: ack flag and write strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            dl_ack <= 1'b0;
            wr_q   <= 1'b0;
        end else begin
            wr_q <= accept;                   // rises with ack
            if (accept)
                dl_ack <= 1'b1;
            else if (dl_ack && !dl_req)
                dl_ack <= 1'b0;               // host let go, close handshake
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= dl_addr;
            data_q <= dl_data;
        end
    end

    assign dl.addr        = addr_q;
    assign dl.data        = data_q;
    assign dl.wr          = wr_q;
    assign dl.downloading = downloading;

endmodule

`default_nettype wire

/* verilog/loader_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// internal buses of the ROM loader
// dl_if.wr and prog_if.we are 1-cycle strobes
// prog_if.busy covers strobe to sdram_ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface dl_if;
    import loader_types_pkg::*;

    dl_addr_t addr;        // held until next accepted byte
    byte_t    data;
    logic     wr;          // one pulse per host byte
    logic     downloading;

    modport source (output addr, data, wr, downloading);
    modport sink   (input  addr, data, wr, downloading);
endinterface

interface prog_if;
    import loader_types_pkg::*;

    sdram_addr_t addr;
    byte_t       data;
    lane_mask_t  mask;
    bank_t       bank;
    logic        we;       // one body byte ready
    logic        busy;     // SDRAM write outstanding

    modport map     (output addr, data, mask, bank, we);
    modport port    (input  addr, data, mask, bank, we, output busy);
    modport monitor (input  busy);
endinterface

`default_nettype wire

/* verilog/rom_header_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM image header layout
// bytes 0..5 three 16-bit region starts
// body begins at FULL_HEADER
// one fixed CPU decryption scheme only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rom_header_pkg;

    parameter int START_BYTES  = 6;   // snd, smp, gfx starts, little endian
    parameter int START_HEADER = 16;  // 6 used, 10 reserved
    parameter int FULL_HEADER  = 64;  // body offset

    // one xor mask per input data bit, bit 0 first
    parameter loader_types_pkg::byte_t DECRYPT_MASKS [8] = '{
        8'h04, 8'h21, 8'h01, 8'h50,
        8'h40, 8'h06, 8'h08, 8'h88
    };

    // these input bits add their mask when low
    parameter loader_types_pkg::byte_t DECRYPT_INVERT = 8'h88;

endpackage

`default_nettype wire

/* verilog/loader_types_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector types shared by the ROM loader
// download addresses are byte addresses, max 32 MB
// SDRAM addresses count 16-bit words
// lane masks are active low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package loader_types_pkg;

    // file byte address from the host
    typedef logic [24:0] dl_addr_t;

    // SDRAM word address, 4M words
    typedef logic [21:0] sdram_addr_t;

    typedef logic [7:0] byte_t;

    // 2'b10 low lane (even byte), 2'b01 high lane (odd byte)
    typedef logic [1:0] lane_mask_t;

    // 01 cpu, 10 graphics, 00 sound and samples
    typedef logic [1:0] bank_t;

    // region start in 1 KB units, as stored in the header
    typedef logic [15:0] region_start_t;

endpackage

`default_nettype wire
